// ==== hw/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// bus widths
`define FETCH_AW 32
`define FETCH_DW 32

// vector base, upper 20 bits
// prefix 0 puts vectors in low memory
`define FETCH_EPH0_P 20'h00000
// prefix 1 puts vectors in high memory
`define FETCH_EPH1_P 20'hF0000

// low byte of every vector
`define FETCH_EXCEPT_V 8'h00

// exception type of the reset vector
`define FETCH_EXCEPT_RESET 4'h1

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

	// flow change requested by decode
	typedef enum logic [2:0] {
		NOP = 3'd0,
		J   = 3'd1,
		JR  = 3'd2,
		BAL = 3'd3,
		BF  = 3'd4,
		BNF = 3'd5,
		RFE = 3'd6
	} branch_op_e;

	// exception type, lands in vector bits 11:8
	typedef logic [3:0] except_type_t;

	// decode control for the next fetch address
	typedef struct packed {
		branch_op_e                 branch_op;
		logic                       flag;
		// word offset or absolute jump target
		logic [`FETCH_AW-1:2]       addr_ofs;
		// word address of the branch itself
		logic [`FETCH_AW-1:2]       binsn_addr;
		logic [`FETCH_AW-1:0]       lr_restor;
		logic [`FETCH_AW-1:0]       epcr;
		logic                       except_start;
		except_type_t               except_type;
		// special-register write to the pc
		logic                       spr_pc_we;
		logic [`FETCH_DW-1:0]       spr_dat;
	} fetch_ctrl_t;

	// one fetched instruction
	typedef struct packed {
		logic                 valid;
		logic [`FETCH_AW-1:0] addr;
		logic [`FETCH_DW-1:0] insn;
		logic                 taken;
	} fetch_rsp_t;

	// candidate next pc, word address
	typedef struct packed {
		logic [`FETCH_AW-1:2] pc;
		logic                 taken;
	} target_t;

endpackage

// ==== hw/branch_target_unit.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module branch_target_unit (
	input  logic [`FETCH_AW-1:2]   pc_i,
	input  fetch_pkg::fetch_ctrl_t ctrl_i,
	output fetch_pkg::target_t     target_o
);
	import fetch_pkg::*;

	// fall-through word address
	logic [`FETCH_AW-1:2] seq_pc;
	// pc-relative word address
	logic [`FETCH_AW-1:2] rel_pc;

	// word arithmetic, no byte bits involved
	assign seq_pc = pc_i + 1'b1;
	assign rel_pc = ctrl_i.binsn_addr + ctrl_i.addr_ofs;

	always_comb begin
		// default is sequential, not taken
		target_o.pc    = seq_pc;
		target_o.taken = 1'b0;
		case (ctrl_i.branch_op)
			NOP: begin
				target_o.pc    = seq_pc;
				target_o.taken = 1'b0;
			end
			J: begin
				// absolute word target
				target_o.pc    = ctrl_i.addr_ofs;
				target_o.taken = 1'b1;
			end
			JR: begin
				// register target, byte bits dropped
				target_o.pc    = ctrl_i.lr_restor[`FETCH_AW-1:2];
				target_o.taken = 1'b1;
			end
			BAL: begin
				target_o.pc    = rel_pc;
				target_o.taken = 1'b1;
			end
			BF: begin
				// taken on flag set
				if (ctrl_i.flag) begin
					target_o.pc    = rel_pc;
					target_o.taken = 1'b1;
				end
			end
			BNF: begin
				// taken on flag clear
				if (!ctrl_i.flag) begin
					target_o.pc    = rel_pc;
					target_o.taken = 1'b1;
				end
			end
			RFE: begin
				// back to saved exception pc
				target_o.pc    = ctrl_i.epcr[`FETCH_AW-1:2];
				target_o.taken = 1'b1;
			end
			default: begin
				// unused encoding falls through
				target_o.pc    = seq_pc;
				target_o.taken = 1'b0;
			end
		endcase
	end

endmodule

// ==== hw/exception_vector_unit.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module exception_vector_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   except_prefix_i,
	input  fetch_pkg::except_type_t except_type_i,
	output fetch_pkg::target_t     vector_o,
	output logic [`FETCH_AW-1:2]   reset_pc_o
);

	logic                 armed_q;
	logic                 prefix_q;
	logic                 reset_prefix;
	logic [19:0]          vec_base;
	logic [19:0]          reset_base;
	logic [`FETCH_AW-1:0] vec_addr;
	logic [`FETCH_AW-1:0] reset_addr;

	// prefix latched on the first clock after reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			armed_q  <= 1'b0;
			prefix_q <= 1'b0;
		end else if (!armed_q) begin
			armed_q  <= 1'b1;
			prefix_q <= except_prefix_i;
		end
	end

	// live prefix only until latched
	assign reset_prefix = armed_q ? prefix_q : except_prefix_i;

	// exception vector: base, type, offset
	assign vec_base  = except_prefix_i ? `FETCH_EPH1_P : `FETCH_EPH0_P;
	assign vec_addr  = {vec_base, except_type_i, `FETCH_EXCEPT_V};
	assign vector_o.pc    = vec_addr[`FETCH_AW-1:2];
	assign vector_o.taken = 1'b1;

	// reset vector from the reset type
	assign reset_base = reset_prefix ? `FETCH_EPH1_P : `FETCH_EPH0_P;
	assign reset_addr = {reset_base, `FETCH_EXCEPT_RESET, `FETCH_EXCEPT_V};
	assign reset_pc_o = reset_addr[`FETCH_AW-1:2];

endmodule

// ==== hw/next_pc_select.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module next_pc_select (
	input  logic                   clk,
	input  logic                   rst,
	input  fetch_pkg::fetch_ctrl_t ctrl_i,
	input  fetch_pkg::target_t     branch_i,
	input  fetch_pkg::target_t     vector_i,
	input  logic [`FETCH_AW-1:2]   reset_pc_i,
	input  logic                   advance_i,
	output logic [`FETCH_AW-1:0]   pc_o,
	output logic                   taken_o
);
	import fetch_pkg::*;

	// combined candidate
	target_t              next_s;
	// set after the first ack
	logic                 loaded_q;
	// current fetch word address
	logic [`FETCH_AW-1:2] pc_q;
	// taken bit of the current address
	logic                 taken_q;

	// fixed priority: spr write, exception, branch unit
	always_comb begin
		if (ctrl_i.spr_pc_we) begin
			next_s.pc    = ctrl_i.spr_dat[`FETCH_AW-1:2];
			next_s.taken = 1'b0;
		end else if (ctrl_i.except_start) begin
			next_s = vector_i;
		end else begin
			next_s = branch_i;
		end
	end

	// first fetch after reset counts as taken
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			loaded_q <= 1'b0;
			taken_q  <= 1'b1;
		end else if (advance_i) begin
			loaded_q <= 1'b1;
			taken_q  <= next_s.taken;
		end
	end

	// advances only on the acked edge
	always_ff @(posedge clk) begin
		if (advance_i) begin
			pc_q <= next_s.pc;
		end
	end

	// reset vector until the first load
	assign pc_o    = {(loaded_q ? pc_q : reset_pc_i), 2'b00};
	assign taken_o = taken_q;

	// decode never raises both redirects in one acked cycle
	assert property (@(posedge clk) disable iff (rst)
		advance_i |-> !(ctrl_i.spr_pc_we && ctrl_i.except_start));

	// a selected exception vector needs a real type
	assert property (@(posedge clk) disable iff (rst)
		advance_i && ctrl_i.except_start && !ctrl_i.spr_pc_we
		|-> ctrl_i.except_type != '0);

endmodule

// ==== hw/wb_fetch_master.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module wb_fetch_master (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`FETCH_AW-1:0]  pc_i,
	input  logic                  taken_i,
	input  logic                  freeze_i,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic [`FETCH_AW-1:0]  wb_adr_o,
	input  logic [`FETCH_DW-1:0]  wb_dat_i,
	input  logic                  wb_ack_i,
	input  logic                  wb_rty_i,
	output logic                  advance_o,
	output fetch_pkg::fetch_rsp_t rsp_o
);

	// bus state, low is idle
	logic                 busy_q;
	logic                 start;
	// address and taken of the cycle on the bus
	logic [`FETCH_AW-1:0] adr_q;
	logic                 taken_q;
	// response register
	logic                 valid_q;
	logic [`FETCH_AW-1:0] rsp_addr_q;
	logic [`FETCH_DW-1:0] rsp_insn_q;
	logic                 rsp_taken_q;

	// new cycle only from idle and not frozen
	assign start = !busy_q && !freeze_i;

	// rty keeps busy, same address goes out again
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			if (wb_ack_i) begin
				busy_q <= 1'b0;
			end
		end else if (start) begin
			busy_q <= 1'b1;
		end
	end

	// capture pc at cycle start
	always_ff @(posedge clk) begin
		if (start) begin
			adr_q   <= pc_i;
			taken_q <= taken_i;
		end
	end

	assign wb_cyc_o  = busy_q;
	assign wb_stb_o  = busy_q;
	assign wb_adr_o  = adr_q;
	assign advance_o = busy_q & wb_ack_i;

	// one-cycle valid after each ack
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= advance_o;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_o) begin
			rsp_addr_q  <= adr_q;
			rsp_insn_q  <= wb_dat_i;
			rsp_taken_q <= taken_q;
		end
	end

	assign rsp_o.valid = valid_q;
	assign rsp_o.addr  = rsp_addr_q;
	assign rsp_o.insn  = rsp_insn_q;
	assign rsp_o.taken = rsp_taken_q;

	// slave ends only a cycle in progress, never with ack and rty together
	assert property (@(posedge clk) disable iff (rst)
		wb_ack_i || wb_rty_i |-> wb_stb_o && !(wb_ack_i && wb_rty_i));

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
	input  logic                   clk,
	input  logic                   rst,
	input  fetch_pkg::fetch_ctrl_t ctrl_i,
	input  logic                   except_prefix_i,
	input  logic                   freeze_i,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic [`FETCH_AW-1:0]   wb_adr_o,
	input  logic [`FETCH_DW-1:0]   wb_dat_i,
	input  logic                   wb_ack_i,
	input  logic                   wb_rty_i,
	output fetch_pkg::fetch_rsp_t  rsp_o
);
	import fetch_pkg::*;

	// candidates from the two side units
	target_t              branch_s;
	target_t              vector_s;
	logic [`FETCH_AW-1:2] reset_pc_s;
	// current fetch address and its taken bit
	logic [`FETCH_AW-1:0] pc_s;
	logic                 taken_s;
	// acked fetch, pc moves on
	logic                 advance_s;

	branch_target_unit branch_target_i (
		.pc_i     (pc_s[`FETCH_AW-1:2]),
		.ctrl_i   (ctrl_i),
		.target_o (branch_s)
	);

	exception_vector_unit exception_vector_i (
		.clk             (clk),
		.rst             (rst),
		.except_prefix_i (except_prefix_i),
		.except_type_i   (ctrl_i.except_type),
		.vector_o        (vector_s),
		.reset_pc_o      (reset_pc_s)
	);

	next_pc_select next_pc_select_i (
		.clk        (clk),
		.rst        (rst),
		.ctrl_i     (ctrl_i),
		.branch_i   (branch_s),
		.vector_i   (vector_s),
		.reset_pc_i (reset_pc_s),
		.advance_i  (advance_s),
		.pc_o       (pc_s),
		.taken_o    (taken_s)
	);

	wb_fetch_master wb_fetch_master_i (
		.clk       (clk),
		.rst       (rst),
		.pc_i      (pc_s),
		.taken_i   (taken_s),
		.freeze_i  (freeze_i),
		.wb_cyc_o  (wb_cyc_o),
		.wb_stb_o  (wb_stb_o),
		.wb_adr_o  (wb_adr_o),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_i  (wb_ack_i),
		.wb_rty_i  (wb_rty_i),
		.advance_o (advance_s),
		.rsp_o     (rsp_o)
	);

endmodule

// ==== sim/fetch_clkgen.sv ====
`timescale 1ns/1ps

module fetch_clkgen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_o
);

	// free-running clock
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset released on a rising edge after a few cycles
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

// ==== sim/wb_imem_model.sv ====
`timescale 1ns/1ps

module wb_imem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [31:0] adr_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic        rty_o
);

	// wait states left in the current transfer
	logic [1:0] wait_q;
	logic       active_q;
	// no two retries in a row
	logic       rty_last_q;
	logic [1:0] waits;

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_o      <= 1'b0;
			rty_o      <= 1'b0;
			dat_o      <= '0;
			wait_q     <= '0;
			active_q   <= 1'b0;
			rty_last_q <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			rty_o <= 1'b0;
			// skip the edge where a response is still on the bus
			if (cyc_i && stb_i && !ack_o && !rty_o) begin
				// fresh draw of 0 to 3 waits at transfer start
				waits = active_q ? wait_q : 2'($urandom % 4);
				if (waits != 2'd0) begin
					active_q <= 1'b1;
					wait_q   <= waits - 2'd1;
				end else begin
					active_q <= 1'b0;
					if (!rty_last_q && ($urandom % 8 == 0)) begin
						rty_o      <= 1'b1;
						rty_last_q <= 1'b1;
					end else begin
						// word is a fixed scramble of the address
						ack_o      <= 1'b1;
						dat_o      <= adr_i ^ 32'h5a5a_a5a5;
						rty_last_q <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== sim/fetch_checker.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  fetch_pkg::fetch_ctrl_t ctrl_i,
	input  logic                   prefix_i,
	input  logic                   freeze_i,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic [31:0]            adr_i,
	input  logic                   ack_i,
	input  fetch_pkg::fetch_rsp_t  rsp_i,
	output int                     errors_o,
	output int                     rsp_count_o
);
	import fetch_pkg::*;

	int          err_cnt = 0;
	int          rsp_cnt = 0;
	// predicted address and taken bit of the fetch on the bus
	logic [31:0] exp_pc;
	logic        exp_taken;
	// acked fetches waiting for their response, {addr, insn, taken}
	logic [64:0] exp_q[$];
	logic [64:0] head;
	logic [32:0] nxt;
	logic        prev_cyc;
	logic        prev_freeze;
	// bus state seen on the previous edge
	logic        prev_ack;
	logic [31:0] prev_adr;

	assign errors_o    = err_cnt;
	assign rsp_count_o = rsp_cnt;

	// next fetch address and taken bit, {pc, taken}
	function automatic logic [32:0] next_pc(fetch_ctrl_t c, logic [31:0] pc, logic prefix);
		logic [29:0] rel;
		logic [32:0] res;
		rel = c.binsn_addr + c.addr_ofs;
		// fall-through unless something redirects
		res = {pc + 32'd4, 1'b0};
		if (c.spr_pc_we) begin
			res = {c.spr_dat[31:2], 2'b00, 1'b0};
		end else if (c.except_start) begin
			res = {(prefix ? `FETCH_EPH1_P : `FETCH_EPH0_P), c.except_type,
				`FETCH_EXCEPT_V, 1'b1};
		end else begin
			case (c.branch_op)
				J:   res = {c.addr_ofs, 2'b00, 1'b1};
				JR:  res = {c.lr_restor[31:2], 2'b00, 1'b1};
				BAL: res = {rel, 2'b00, 1'b1};
				BF:  if (c.flag) res = {rel, 2'b00, 1'b1};
				BNF: if (!c.flag) res = {rel, 2'b00, 1'b1};
				RFE: res = {c.epcr[31:2], 2'b00, 1'b1};
				default: ;
			endcase
		end
		return res;
	endfunction

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("Error: %s expected 0x%08h got 0x%08h at %0t", name, exp, act, $time);
		end
	endtask

	// all sampling on the rising edge, pre-edge values
	always @(posedge clk) begin
		if (rst) begin
			if (cyc_i || stb_i || rsp_i.valid) begin
				err_cnt++;
				$display("bus cycle or response active during reset at %0t", $time);
			end
			// first fetch goes to the reset vector, marked taken
			exp_pc      <= 32'h0000_0100;
			exp_taken   <= 1'b1;
			prev_cyc    <= 1'b0;
			prev_freeze <= 1'b0;
			prev_ack    <= 1'b0;
			prev_adr    <= '0;
			exp_q.delete();
		end else begin
			// response side
			if (rsp_i.valid) begin
				rsp_cnt++;
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("response at %0t with no acked fetch pending", $time);
				end else begin
					head = exp_q.pop_front();
					check_value("rsp_o.addr", head[64:33], rsp_i.addr);
					check_value("rsp_o.insn", head[32:1], rsp_i.insn);
					check_value("rsp_o.taken", {31'd0, head[0]}, {31'd0, rsp_i.taken});
				end
			end
			// bus side, ctrl as seen in the ack cycle
			if (cyc_i && ack_i) begin
				check_value("wb_adr_o", exp_pc, adr_i);
				exp_q.push_back({exp_pc, exp_pc ^ 32'h5a5a_a5a5, exp_taken});
				nxt = next_pc(ctrl_i, exp_pc, prefix_i);
				exp_pc    <= nxt[32:1];
				exp_taken <= nxt[0];
			end
			// no cycle may start out of a frozen idle cycle
			if (cyc_i && !prev_cyc && prev_freeze) begin
				err_cnt++;
				$display("wb_cyc_o rose at %0t although freeze_i was high", $time);
			end
			// stb travels with cyc
			if (cyc_i !== stb_i) begin
				err_cnt++;
				$display("wb_stb_o and wb_cyc_o differ at %0t", $time);
			end
			// waits and retries hold the cycle and its address
			if (prev_cyc && !prev_ack) begin
				if (!cyc_i) begin
					err_cnt++;
					$display("bus cycle dropped at %0t before its ack", $time);
				end else begin
					check_value("wb_adr_o", prev_adr, adr_i);
				end
			end
			prev_cyc    <= cyc_i;
			prev_freeze <= freeze_i;
			prev_ack    <= ack_i;
			prev_adr    <= adr_i;
		end
	end

endmodule

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int FETCHES = 400;
	// ten cycles per fetch is generous, plus reset slack
	localparam int LIMIT   = FETCHES * 10 + 100;

	logic        clk;
	logic        rst;
	fetch_ctrl_t ctrl;
	logic        prefix;
	logic        freeze;
	logic        wb_cyc;
	logic        wb_stb;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat;
	logic        wb_ack;
	logic        wb_rty;
	fetch_rsp_t  rsp;
	int          errors;
	int          rsp_count;
	int          cycles;
	logic        stalled;

	fetch_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clkgen_i (
		.clk_o (clk),
		.rst_o (rst)
	);

	fetch_top dut_i (
		.clk             (clk),
		.rst             (rst),
		.ctrl_i          (ctrl),
		.except_prefix_i (prefix),
		.freeze_i        (freeze),
		.wb_cyc_o        (wb_cyc),
		.wb_stb_o        (wb_stb),
		.wb_adr_o        (wb_adr),
		.wb_dat_i        (wb_dat),
		.wb_ack_i        (wb_ack),
		.wb_rty_i        (wb_rty),
		.rsp_o           (rsp)
	);

	wb_imem_model imem_i (
		.clk   (clk),
		.rst   (rst),
		.cyc_i (wb_cyc),
		.stb_i (wb_stb),
		.adr_i (wb_adr),
		.dat_o (wb_dat),
		.ack_o (wb_ack),
		.rty_o (wb_rty)
	);

	fetch_checker checker_i (
		.clk         (clk),
		.rst         (rst),
		.ctrl_i      (ctrl),
		.prefix_i    (prefix),
		.freeze_i    (freeze),
		.cyc_i       (wb_cyc),
		.stb_i       (wb_stb),
		.adr_i       (wb_adr),
		.ack_i       (wb_ack),
		.rsp_i       (rsp),
		.errors_o    (errors),
		.rsp_count_o (rsp_count)
	);

	// random decode control, redirects never both at once
	function automatic fetch_ctrl_t random_ctrl();
		fetch_ctrl_t c;
		int          kind;
		kind         = $urandom % 16;
		c            = '0;
		c.branch_op  = branch_op_e'(3'($urandom % 7));
		c.flag       = 1'($urandom);
		c.addr_ofs   = 30'($urandom);
		c.binsn_addr = 30'($urandom);
		c.lr_restor  = $urandom;
		c.epcr       = $urandom;
		c.spr_dat    = $urandom;
		// type 0 is not a valid vector
		c.except_type = 4'($urandom % 15 + 1);
		if (kind == 0) begin
			c.spr_pc_we = 1'b1;
		end else if (kind == 1) begin
			c.except_start = 1'b1;
		end else if (kind < 8) begin
			// keep some sequential runs
			c.branch_op = NOP;
		end
		return c;
	endfunction

	// ctrl only moves on the ack edge, so it is stable per fetch
	always @(posedge clk) begin
		if (rst) begin
			ctrl   <= '0;
			prefix <= 1'b0;
			freeze <= 1'b0;
		end else begin
			if (wb_cyc && wb_ack) begin
				ctrl   <= random_ctrl();
				prefix <= 1'($urandom);
			end
			// freeze comes in short bursts
			freeze <= freeze ? ($urandom % 2 == 0) : ($urandom % 8 == 0);
		end
	end

	initial begin
		void'($urandom(32'h80c9_607f));
		ctrl    = '0;
		prefix  = 1'b0;
		freeze  = 1'b0;
		cycles  = 0;
		stalled = 1'b0;
		while (rsp_count < FETCHES && cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (rsp_count < FETCHES) begin
			stalled = 1'b1;
			$display("fetch stream stalled: %0d of %0d responses after %0d cycles",
				rsp_count, FETCHES, cycles);
		end
		$display("errors: %0d, responses: %0d, cycles: %0d", errors, rsp_count, cycles);
		if (errors == 0 && !stalled) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/branch_target_unit.sv
hw/exception_vector_unit.sv
hw/next_pc_select.sv
hw/wb_fetch_master.sv
hw/fetch_top.sv
sim/fetch_clkgen.sv
sim/wb_imem_model.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/branch_target_unit.sv
      - hw/exception_vector_unit.sv
      - hw/next_pc_select.sv
      - hw/wb_fetch_master.sv
      - hw/fetch_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/fetch_clkgen.sv
      - sim/wb_imem_model.sv
      - sim/fetch_checker.sv
      - sim/fetch_tb.sv
